/* logic/trdb_defines.svh */
// Trace debugger widths and sizes shared by every block of the packet path
`ifndef TRDB_DEFINES_SVH
`define TRDB_DEFINES_SVH

// Instruction address width
`define TRDB_XLEN 32

// Trap cause and privilege level widths
`define TRDB_CAUSELEN 5
`define TRDB_PRIVLEN 2

// Branch map holds at most this many outcomes
`define TRDB_BMAP_LEN 31

// Packet vector width, the longest packet uses 70 bits
`define TRDB_PACKET_LEN 72
`define TRDB_LEN_W 7

// Resync period register width
`define TRDB_PERIOD_W 8

`endif

/* logic/trdb_pkg.sv */
// Trace debugger package with width types, packet formats and the instruction record
`include "trdb_defines.svh"

package trdb_pkg;

    typedef logic [`TRDB_XLEN-1:0] trdb_addr_t;
    typedef logic [`TRDB_CAUSELEN-1:0] trdb_cause_t;
    typedef logic [`TRDB_PRIVLEN-1:0] trdb_priv_t;
    // Bit 0 holds the oldest outcome
    typedef logic [`TRDB_BMAP_LEN-1:0] trdb_bmap_t;
    typedef logic [4:0] trdb_bcnt_t;
    typedef logic [`TRDB_LEN_W-1:0] trdb_plen_t;

    typedef enum logic [1:0] {
        F_BRANCH_FULL = 2'd0,
        F_BRANCH_DIFF = 2'd1,
        F_ADDR_ONLY   = 2'd2,
        F_SYNC        = 2'd3
    } trdb_format_t;

    typedef enum logic [1:0] {
        SF_START     = 2'd0,
        SF_EXCEPTION = 2'd1
    } trdb_subformat_t;

    // One retired instruction as reported by the core
    typedef struct packed {
        logic        valid;
        trdb_addr_t  iaddr;
        trdb_priv_t  priv;
        logic        is_branch;
        logic        taken;
        logic        is_jump;
        logic        exception;
        logic        interrupt;
        trdb_cause_t cause;
    } trdb_instr_t;

    typedef struct packed {
        logic [`TRDB_PACKET_LEN-1:0] bits;
        trdb_plen_t                  len;
    } trdb_packet_t;

endpackage

/* logic/trdb_cfg_regs.sv */
// Trace debugger configuration registers with enable edge detection for trace start
`timescale 1ns/1ps
`include "trdb_defines.svh"

module trdb_cfg_regs (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic                      cfg_we_i,
    input  logic                      cfg_addr_i,
    input  logic [31:0]               cfg_wdata_i,
    output logic                      enable_o,
    output logic [`TRDB_PERIOD_W-1:0] sync_period_o,
    output logic                      trace_start_o
);

    logic                      enable_q;
    logic                      enable_prev_q;
    logic [`TRDB_PERIOD_W-1:0] period_q;

    // Address 0 holds enable, address 1 the resync period
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            enable_q <= 1'b0;
            period_q <= '0;
        end else if (cfg_we_i) begin
            if (cfg_addr_i == 1'b0) begin
                enable_q <= cfg_wdata_i[0];
            end else begin
                period_q <= cfg_wdata_i[`TRDB_PERIOD_W-1:0];
            end
        end
    end

    // Previous enable for the rising edge
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            enable_prev_q <= 1'b0;
        end else begin
            enable_prev_q <= enable_q;
        end
    end

    assign enable_o      = enable_q;
    assign sync_period_o = period_q;

    // High in the first enabled cycle only
    assign trace_start_o = enable_q && !enable_prev_q;

endmodule

/* logic/trdb_branch_map.sv */
// Branch map that collects taken and not-taken outcomes in retirement order
`timescale 1ns/1ps
`include "trdb_defines.svh"

module trdb_branch_map (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   record_i,
    input  logic                   taken_i,
    input  logic                   clear_i,
    output trdb_pkg::trdb_bmap_t   map_o,
    output trdb_pkg::trdb_bcnt_t   count_o
);

    import trdb_pkg::*;

    trdb_bmap_t map_q;
    trdb_bcnt_t count_q;

    // Clear has priority over a record in the same cycle
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            map_q   <= '0;
            count_q <= '0;
        end else if (clear_i) begin
            map_q   <= '0;
            count_q <= '0;
        end else if (record_i) begin
            map_q[count_q] <= taken_i;
            count_q        <= count_q + trdb_bcnt_t'(1);
        end
    end

    assign map_o   = map_q;
    assign count_o = count_q;

    // A full map must be flushed by control before another outcome arrives
    property p_no_record_when_full;
        @(posedge clk_i) disable iff (!rst_ni)
        record_i && !clear_i |-> count_q != trdb_bcnt_t'(`TRDB_BMAP_LEN);
    endproperty

    a_no_record_when_full: assert property (p_no_record_when_full)
        else $error("branch map recorded with %0d outcomes held", count_q);

    // Filling the map always comes with a clear in the same cycle
    property p_full_is_flushed;
        @(posedge clk_i) disable iff (!rst_ni)
        record_i && count_q == trdb_bcnt_t'(`TRDB_BMAP_LEN - 1) |-> clear_i;
    endproperty

    a_full_is_flushed: assert property (p_full_is_flushed)
        else $error("branch map filled without a flush");

endmodule

/* logic/trdb_packet_control.sv */
// Packet control choosing the packet format per retired instruction and tracking resync
`timescale 1ns/1ps
`include "trdb_defines.svh"

module trdb_packet_control (
    input  logic                         clk_i,
    input  logic                         rst_ni,
    input  trdb_pkg::trdb_instr_t        instr_i,
    input  logic                         enable_i,
    input  logic [`TRDB_PERIOD_W-1:0]    sync_period_i,
    input  logic                         trace_start_i,
    input  trdb_pkg::trdb_bcnt_t         count_i,
    output logic                         emit_o,
    output trdb_pkg::trdb_format_t       format_o,
    output trdb_pkg::trdb_subformat_t    subformat_o,
    output logic                         record_o,
    output logic                         clear_o
);

    import trdb_pkg::*;

    logic                      start_flag_q, start_flag_d;
    logic [`TRDB_PERIOD_W-1:0] pkt_cnt_q, pkt_cnt_d;
    logic                      active;
    logic                      period_due;
    logic                      start_pending;
    logic                      map_empty;
    logic                      map_fills;
    logic                      sync_emit;

    assign active        = enable_i && instr_i.valid;
    assign period_due    = (sync_period_i != '0) && (pkt_cnt_q >= sync_period_i);
    assign start_pending = start_flag_q || trace_start_i || period_due;
    assign map_empty     = (count_i == '0);
    // This branch would be the last one the map can take
    assign map_fills     = (count_i == trdb_bcnt_t'(`TRDB_BMAP_LEN - 1));

    always_comb begin
        emit_o      = 1'b0;
        format_o    = F_ADDR_ONLY;
        subformat_o = SF_START;
        record_o    = 1'b0;
        clear_o     = 1'b0;
        if (active) begin
            if (start_pending) begin
                emit_o   = 1'b1;
                format_o = F_SYNC;
                clear_o  = 1'b1;
            end else if (instr_i.exception) begin
                emit_o      = 1'b1;
                format_o    = F_SYNC;
                subformat_o = SF_EXCEPTION;
                clear_o     = 1'b1;
            end else if (instr_i.is_jump) begin
                emit_o   = 1'b1;
                format_o = map_empty ? F_ADDR_ONLY : F_BRANCH_FULL;
                clear_o  = !map_empty;
            end else if (instr_i.is_branch) begin
                record_o = 1'b1;
                if (map_fills) begin
                    emit_o   = 1'b1;
                    format_o = F_BRANCH_FULL;
                    clear_o  = 1'b1;
                end
            end
        end
    end

    assign sync_emit = emit_o && (format_o == F_SYNC);

    // Start stays pending until an instruction carries the sync
    always_comb begin
        start_flag_d = start_flag_q || trace_start_i;
        if ((sync_emit && subformat_o == SF_START) || !enable_i) begin
            start_flag_d = 1'b0;
        end
        pkt_cnt_d = pkt_cnt_q;
        if (sync_emit) begin
            pkt_cnt_d = '0;
        end else if (emit_o && pkt_cnt_q != '1) begin
            pkt_cnt_d = pkt_cnt_q + 1'b1;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            start_flag_q <= 1'b0;
            pkt_cnt_q    <= '0;
        end else begin
            start_flag_q <= start_flag_d;
            pkt_cnt_q    <= pkt_cnt_d;
        end
    end

    // The map count seen here must never have reached full capacity
    a_no_emit_record_full: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        emit_o || record_o |-> count_i != trdb_bcnt_t'(`TRDB_BMAP_LEN))
        else $error("packet control acted on a map holding %0d outcomes", count_i);

endmodule

/* logic/trdb_packet_emitter.sv */
// Packet emitter assembling and registering the packet bits and length per format
`timescale 1ns/1ps
`include "trdb_defines.svh"

module trdb_packet_emitter (
    input  logic                         clk_i,
    input  logic                         rst_ni,
    input  logic                         emit_i,
    input  trdb_pkg::trdb_format_t       format_i,
    input  trdb_pkg::trdb_subformat_t    subformat_i,
    input  trdb_pkg::trdb_instr_t        instr_i,
    input  trdb_pkg::trdb_bmap_t         map_i,
    input  trdb_pkg::trdb_bcnt_t         count_i,
    output trdb_pkg::trdb_packet_t       packet_o,
    output logic                         valid_o
);

    import trdb_pkg::*;

    // Format, subformat, priv, is_branch, iaddr, cause and interrupt
    localparam int unsigned SyncLen = 2 + 2 + `TRDB_PRIVLEN + 1 + `TRDB_XLEN
                                      + `TRDB_CAUSELEN + 1;

    trdb_bcnt_t   eff_count;
    trdb_bmap_t   eff_map;
    trdb_bcnt_t   bucket;
    trdb_packet_t packet_d;
    trdb_packet_t packet_q;
    logic         valid_q;

    // A full map from a branch still lacks this outcome in the register
    always_comb begin
        eff_count = count_i;
        eff_map   = map_i;
        if (format_i == F_BRANCH_FULL && !instr_i.is_jump) begin
            eff_map[count_i] = instr_i.taken;
            eff_count        = count_i + trdb_bcnt_t'(1);
        end
    end

    // Smallest map field that holds all outcomes
    always_comb begin
        if (eff_count <= 5'd1) begin
            bucket = 5'd1;
        end else if (eff_count <= 5'd9) begin
            bucket = 5'd9;
        end else if (eff_count <= 5'd17) begin
            bucket = 5'd17;
        end else if (eff_count <= 5'd25) begin
            bucket = 5'd25;
        end else begin
            bucket = 5'd31;
        end
    end

    always_comb begin
        packet_d = '0;
        if (emit_i) begin
            packet_d.bits[1:0] = format_i;
            case (format_i)
                F_BRANCH_FULL: begin
                    packet_d.bits[6:2] = eff_count;
                    case (bucket)
                        5'd1:  packet_d.bits[7 +: 1 + `TRDB_XLEN] = {instr_i.iaddr, eff_map[0]};
                        5'd9:  packet_d.bits[7 +: 9 + `TRDB_XLEN] = {instr_i.iaddr, eff_map[8:0]};
                        5'd17: packet_d.bits[7 +: 17 + `TRDB_XLEN] = {instr_i.iaddr, eff_map[16:0]};
                        5'd25: packet_d.bits[7 +: 25 + `TRDB_XLEN] = {instr_i.iaddr, eff_map[24:0]};
                        default: packet_d.bits[7 +: 31 + `TRDB_XLEN] = {instr_i.iaddr, eff_map};
                    endcase
                    packet_d.len = trdb_plen_t'(7 + `TRDB_XLEN) + trdb_plen_t'(bucket);
                end
                F_ADDR_ONLY: begin
                    packet_d.bits[2 +: `TRDB_XLEN] = instr_i.iaddr;
                    packet_d.len = trdb_plen_t'(2 + `TRDB_XLEN);
                end
                F_SYNC: begin
                    packet_d.bits[2 +: SyncLen - 2] = {instr_i.interrupt, instr_i.cause,
                        instr_i.iaddr, instr_i.is_branch, instr_i.priv, subformat_i};
                    packet_d.len = trdb_plen_t'(SyncLen);
                end
                // Differential branch packets are never produced
                default: begin
                end
            endcase
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= emit_i;
        end
    end

    always_ff @(posedge clk_i) begin
        packet_q <= packet_d;
    end

    assign packet_o = packet_q;
    assign valid_o  = valid_q;

    a_no_branch_diff: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        emit_i |-> format_i != F_BRANCH_DIFF)
        else $error("differential branch format requested");

endmodule

/* logic/trdb_top.sv */
// Trace debugger packet path joining configuration, branch map, control and emitter
`timescale 1ns/1ps
`include "trdb_defines.svh"

module trdb_top (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  trdb_pkg::trdb_instr_t   instr_i,
    input  logic                    cfg_we_i,
    input  logic                    cfg_addr_i,
    input  logic [31:0]             cfg_wdata_i,
    output trdb_pkg::trdb_packet_t  packet_o,
    output logic                    packet_valid_o
);

    import trdb_pkg::*;

    logic                      enable;
    logic                      trace_start;
    logic [`TRDB_PERIOD_W-1:0] sync_period;
    trdb_bmap_t                map;
    trdb_bcnt_t                count;
    logic                      emit;
    logic                      record;
    logic                      clear;
    trdb_format_t              format;
    trdb_subformat_t           subformat;

    trdb_cfg_regs i_cfg_regs (
        .clk_i, .rst_ni, .cfg_we_i, .cfg_addr_i, .cfg_wdata_i,
        .enable_o(enable), .sync_period_o(sync_period), .trace_start_o(trace_start)
    );

    trdb_branch_map i_branch_map (
        .clk_i, .rst_ni, .record_i(record), .taken_i(instr_i.taken), .clear_i(clear),
        .map_o(map), .count_o(count)
    );

    trdb_packet_control i_packet_control (
        .clk_i, .rst_ni, .instr_i, .enable_i(enable), .sync_period_i(sync_period),
        .trace_start_i(trace_start), .count_i(count), .emit_o(emit), .format_o(format),
        .subformat_o(subformat), .record_o(record), .clear_o(clear)
    );

    trdb_packet_emitter i_packet_emitter (
        .clk_i, .rst_ni, .emit_i(emit), .format_i(format), .subformat_i(subformat),
        .instr_i, .map_i(map), .count_i(count), .packet_o, .valid_o(packet_valid_o)
    );

endmodule

/* test/tb_trdb.sv */
// Testbench for the trace debugger packet path with table tests and a random stream
`timescale 1ns/1ps
`include "trdb_defines.svh"

module tb_trdb;

    import trdb_pkg::*;

    // One applied cycle, either a configuration write or an instruction
    typedef struct packed {
        logic [2:0]   test_id;
        logic         is_cfg;
        logic         cfg_addr;
        logic [31:0]  cfg_data;
        trdb_instr_t  instr;
        logic         has_exp;
        logic         exp_valid;
        trdb_format_t exp_format;
        trdb_plen_t   exp_len;
    } step_t;

    localparam int NumTests = 6;

    logic         clk_i;
    logic         rst_ni;
    trdb_instr_t  instr_i;
    logic         cfg_we_i;
    logic         cfg_addr_i;
    logic [31:0]  cfg_wdata_i;
    trdb_packet_t packet_o;
    logic         packet_valid_o;

    step_t        steps[$];
    string        test_names[NumTests];
    int           test_checks[NumTests];
    int           test_errors[NumTests];
    logic [31:0]  lcg_state;
    logic [31:0]  pc;
    logic         table_ready;

    // Reference model state
    logic         m_en;
    logic         m_start;
    int           m_period;
    int           m_pkt;
    trdb_bmap_t   m_map;
    int           m_cnt;

    trdb_top i_trdb_top (
        .clk_i, .rst_ni, .instr_i, .cfg_we_i, .cfg_addr_i, .cfg_wdata_i,
        .packet_o, .packet_valid_o
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Smallest map field that covers cnt outcomes
    function automatic int field_width(int cnt);
        if (cnt <= 1) return 1;
        if (cnt <= 9) return 9;
        if (cnt <= 17) return 17;
        if (cnt <= 25) return 25;
        return 31;
    endfunction

    // Kinds are 0 plain, 1 branch, 2 jump and 3 exception
    function automatic trdb_instr_t make_instr(int kind, logic taken);
        trdb_instr_t ins;
        ins = '0;
        pc = pc + 32'd4;
        ins.valid = 1'b1;
        ins.iaddr = pc;
        ins.priv = pc[3:2];
        ins.is_branch = (kind == 1);
        ins.taken = (kind == 1) && taken;
        ins.is_jump = (kind == 2);
        ins.exception = (kind == 3);
        ins.interrupt = (kind == 3) && pc[4];
        ins.cause = pc[9:5];
        return ins;
    endfunction

    function automatic trdb_packet_t build_packet(trdb_format_t f, trdb_subformat_t sf,
            trdb_instr_t ins, trdb_bmap_t m, int cnt);
        trdb_packet_t p;
        int b;
        p = '0;
        p.bits[1:0] = f;
        if (f == F_SYNC) begin
            p.bits[3:2] = sf;
            p.bits[5:4] = ins.priv;
            p.bits[6] = ins.is_branch;
            p.bits[38:7] = ins.iaddr;
            p.bits[43:39] = ins.cause;
            p.bits[44] = ins.interrupt;
            p.len = 7'd45;
        end else if (f == F_ADDR_ONLY) begin
            p.bits[33:2] = ins.iaddr;
            p.len = 7'd34;
        end else begin
            b = field_width(cnt);
            p.bits[6:2] = 5'(cnt);
            for (int k = 0; k < b; k++) begin
                p.bits[7 + k] = m[k];
            end
            p.bits[7 + b +: 32] = ins.iaddr;
            p.len = 7'(39 + b);
        end
        return p;
    endfunction

    // Address field position follows from format and length
    function automatic trdb_addr_t packet_addr(trdb_packet_t p);
        if (p.bits[1:0] == F_SYNC) return p.bits[38:7];
        if (p.bits[1:0] == F_ADDR_ONLY) return p.bits[33:2];
        return p.bits[int'(p.len) - 32 +: 32];
    endfunction

    task automatic add_instr(int test, trdb_instr_t ins, logic ev, trdb_format_t f, int len);
        step_t s;
        s = '0;
        s.test_id = test[2:0];
        s.instr = ins;
        s.has_exp = 1'b1;
        s.exp_valid = ev;
        s.exp_format = f;
        s.exp_len = len[6:0];
        steps.push_back(s);
    endtask

    task automatic add_cfg(int test, logic addr, logic [31:0] data);
        step_t s;
        s = '0;
        s.test_id = test[2:0];
        s.is_cfg = 1'b1;
        s.cfg_addr = addr;
        s.cfg_data = data;
        s.has_exp = 1'b1;
        steps.push_back(s);
    endtask

    task automatic build_table();
        int          counts[6];
        logic [31:0] r;
        logic [3:0]  sel;
        int          kind;
        step_t       s;
        counts = '{0, 1, 8, 9, 20, 30};
        test_names = '{"disabled_then_start", "jump_after_branches", "full_map",
                       "exception_discard", "periodic_resync", "random_stream"};
        add_instr(0, make_instr(0, 1'b0), 1'b0, F_SYNC, 0);
        add_instr(0, make_instr(1, 1'b1), 1'b0, F_SYNC, 0);
        add_instr(0, make_instr(2, 1'b0), 1'b0, F_SYNC, 0);
        add_cfg(0, 1'b0, 32'h1);
        add_instr(0, make_instr(0, 1'b0), 1'b1, F_SYNC, 45);
        foreach (counts[i]) begin
            for (int k = 0; k < counts[i]; k++) begin
                r = lcg_next();
                add_instr(1, make_instr(1, r[7]), 1'b0, F_BRANCH_FULL, 0);
            end
            add_instr(1, make_instr(2, 1'b0), 1'b1,
                      counts[i] == 0 ? F_ADDR_ONLY : F_BRANCH_FULL,
                      counts[i] == 0 ? 34 : 39 + field_width(counts[i]));
        end
        for (int k = 0; k < 30; k++) begin
            r = lcg_next();
            add_instr(2, make_instr(1, r[9]), 1'b0, F_BRANCH_FULL, 0);
        end
        add_instr(2, make_instr(1, 1'b1), 1'b1, F_BRANCH_FULL, 70);
        add_instr(2, make_instr(1, 1'b1), 1'b0, F_BRANCH_FULL, 0);
        add_instr(2, make_instr(2, 1'b0), 1'b1, F_BRANCH_FULL, 40);
        for (int k = 0; k < 5; k++) begin
            add_instr(3, make_instr(1, 1'b1), 1'b0, F_BRANCH_FULL, 0);
        end
        add_instr(3, make_instr(3, 1'b0), 1'b1, F_SYNC, 45);
        add_instr(3, make_instr(2, 1'b0), 1'b1, F_ADDR_ONLY, 34);
        // Exception sync first so the packet count starts from zero
        add_instr(4, make_instr(3, 1'b0), 1'b1, F_SYNC, 45);
        add_cfg(4, 1'b1, 32'd3);
        for (int n = 0; n < 2; n++) begin
            for (int k = 0; k < 3; k++) begin
                add_instr(4, make_instr(2, 1'b0), 1'b1, F_ADDR_ONLY, 34);
            end
            add_instr(4, make_instr(0, 1'b0), 1'b1, F_SYNC, 45);
        end
        add_cfg(4, 1'b1, 32'd0);
        add_cfg(5, 1'b1, 32'd7);
        for (int k = 0; k < 400; k++) begin
            r = lcg_next();
            sel = r[7:4];
            kind = (sel == 4'd0) ? 3 : (sel < 4'd3) ? 2 : (sel < 4'd11) ? 1 : 0;
            s = '0;
            s.test_id = 3'd5;
            s.instr = make_instr(kind, r[8]);
            s.instr.valid = (r[3:0] != 4'd0);
            steps.push_back(s);
        end
    endtask

    task automatic model_step(step_t s, output logic ev, output trdb_packet_t ep);
        logic pending;
        ev = 1'b0;
        ep = '0;
        if (s.is_cfg) begin
            if (s.cfg_addr == 1'b0) begin
                if (s.cfg_data[0] && !m_en) m_start = 1'b1;
                if (!s.cfg_data[0]) m_start = 1'b0;
                m_en = s.cfg_data[0];
            end else begin
                m_period = int'(s.cfg_data[7:0]);
            end
        end else if (m_en && s.instr.valid) begin
            pending = m_start || (m_period != 0 && m_pkt >= m_period);
            if (pending || s.instr.exception) begin
                ev = 1'b1;
                ep = build_packet(F_SYNC, pending ? SF_START : SF_EXCEPTION, s.instr, m_map, 0);
                m_start = 1'b0;
                m_pkt = 0;
                m_map = '0;
                m_cnt = 0;
            end else if (s.instr.is_jump) begin
                ev = 1'b1;
                if (m_cnt == 0) begin
                    ep = build_packet(F_ADDR_ONLY, SF_START, s.instr, m_map, 0);
                end else begin
                    ep = build_packet(F_BRANCH_FULL, SF_START, s.instr, m_map, m_cnt);
                end
                m_pkt++;
                m_map = '0;
                m_cnt = 0;
            end else if (s.instr.is_branch) begin
                m_map[m_cnt] = s.instr.taken;
                m_cnt++;
                if (m_cnt == `TRDB_BMAP_LEN) begin
                    ev = 1'b1;
                    ep = build_packet(F_BRANCH_FULL, SF_START, s.instr, m_map, m_cnt);
                    m_pkt++;
                    m_map = '0;
                    m_cnt = 0;
                end
            end
        end
    endtask

    task automatic drive_step(step_t s);
        cfg_we_i = s.is_cfg;
        cfg_addr_i = s.cfg_addr;
        cfg_wdata_i = s.cfg_data;
        instr_i = s.is_cfg ? trdb_instr_t'('0) : s.instr;
    endtask

    task automatic check_value(int test, string what, logic [79:0] expected,
            logic [79:0] actual);
        test_checks[test]++;
        if (expected !== actual) begin
            test_errors[test]++;
            $display("ERROR %s %s: expected %h, actual %h", test_names[test], what,
                     expected, actual);
        end
    endtask

    task automatic check_step(int idx, step_t s, logic ev, trdb_packet_t ep);
        string tag;
        int    t;
        t = int'(s.test_id);
        tag = $sformatf("step %0d", idx);
        check_value(t, {tag, " valid"}, 80'(ev), 80'(packet_valid_o));
        if (ev) check_value(t, {tag, " packet"}, 80'(ep), 80'(packet_o));
        if (s.has_exp) begin
            check_value(t, {tag, " table valid"}, 80'(s.exp_valid), 80'(packet_valid_o));
            if (s.exp_valid) begin
                check_value(t, {tag, " format"}, 80'(s.exp_format), 80'(packet_o.bits[1:0]));
                check_value(t, {tag, " length"}, 80'(s.exp_len), 80'(packet_o.len));
                check_value(t, {tag, " address"}, 80'(s.instr.iaddr),
                            80'(packet_addr(packet_o)));
            end
        end
    endtask

    task automatic report_test(int t);
        $display("test %0d %s: %0d checks, %0d errors", t, test_names[t],
                 test_checks[t], test_errors[t]);
    endtask

    // Allowed time is one clock period per step plus reset and a margin
    initial begin
        wait (table_ready);
        repeat (steps.size() + 8 + 20) #100;
        $display("watchdog expired before all %0d steps were applied", steps.size());
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        logic         ev;
        trdb_packet_t ep;
        int           cur;
        int           total_checks;
        int           total_errors;
        table_ready = 1'b0;
        rst_ni = 1'b0;
        instr_i = '0;
        cfg_we_i = 1'b0;
        cfg_addr_i = 1'b0;
        cfg_wdata_i = '0;
        lcg_state = 32'h54ee;
        pc = 32'h8000_0000;
        m_en = 1'b0;
        m_start = 1'b0;
        m_period = 0;
        m_pkt = 0;
        m_map = '0;
        m_cnt = 0;
        build_table();
        table_ready = 1'b1;
        repeat (8) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;
        @(negedge clk_i);
        cur = 0;
        // Check the previous cycle and drive the next one on the same falling edge
        foreach (steps[i]) begin
            if (int'(steps[i].test_id) != cur) begin
                report_test(cur);
                cur = int'(steps[i].test_id);
            end
            drive_step(steps[i]);
            model_step(steps[i], ev, ep);
            @(negedge clk_i);
            check_step(i, steps[i], ev, ep);
        end
        report_test(cur);
        total_checks = 0;
        total_errors = 0;
        for (int t = 0; t < NumTests; t++) begin
            total_checks += test_checks[t];
            total_errors += test_errors[t];
        end
        $display("%0d tests, %0d checks, %0d errors", NumTests, total_checks, total_errors);
        if (total_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* flist.f */
+incdir+logic
logic/trdb_pkg.sv
logic/trdb_cfg_regs.sv
logic/trdb_branch_map.sv
logic/trdb_packet_control.sv
logic/trdb_packet_emitter.sv
logic/trdb_top.sv
test/tb_trdb.sv

/* run.sh */
#!/bin/sh
# Builds and runs the trace debugger testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 -f flist.f --top-module tb_trdb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_trdb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "TEST OK"; then
    exit 0
fi
echo "pass line not found in simulation output"
exit 1
